/* sim/i2c_patterns.hex */
// words 0-5 register address and value, word 6 the SCL half period for the host to write
// words 7-12 ack mask per transfer, bit 2 address, bit 1 register, bit 0 data byte, 1 acks
03FF
0F00
1C0E
2C00
104F
03FE
000C
0007
0007
0007
0007
0007
0006

/* verilog.f */
+incdir+hdl
hdl/i2c_pkg.sv
hdl/sb_arbiter.sv
hdl/i2c_master.sv
hdl/synth_config.sv
hdl/i2c_subsystem.sv
sim/i2c_assertions.sv
sim/i2c_tb.sv

/* Makefile */
# Verilator flow for the I2C configuration subsystem

TOP := i2c_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

# the run passes only if the testbench prints its pass line
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x 'TB PASSED' > /dev/null

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

/* sim/i2c_tb.sv */
// ==========================================================
// I2C configuration subsystem testbench
// drives the host bus, models the I2C slave on the pins and
// checks register access, transfers and the final verdict
// ==========================================================
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_tb;

    // table words, then the host period, then one ack mask per transfer
    localparam int NUM_PATTERNS = 2 * `SYNTH_TABLE_LEN + 1;
    localparam logic [6:0] SLAVE_ADDR = 7'h60;

    logic             clock;
    logic             rst;
    logic             start;
    logic [6:0]       slave_address;
    i2c_pkg::sb_req_t host_req;
    logic             scl_in;
    logic             sda_in;
    logic [31:0]      host_rdata;
    logic             host_rvalid;
    logic             done;
    logic             scl_out;
    logic             scl_out_en;
    logic             sda_out;
    logic             sda_out_en;

    logic [15:0] patterns [0:NUM_PATTERNS-1];
    logic [15:0] half_period;
    logic [15:0] lfsr;
    int          timeout_cycles;
    int          cycle_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          host_reads = 0;
    int          host_responses;
    int          done_pulses;
    int          stops_at_done;

    // slave model state
    logic        sda_pull = 1'b0;
    logic        scl_prev;
    logic        sda_prev;
    logic        in_xfer;
    int          bit_cnt;
    int          xfer_idx;
    int          level_len;
    int          min_level;
    logic [26:0] shift_in;
    logic [23:0] xfers [$];

    // open-drain lines, low only while someone pulls them down
    assign scl_in = !(scl_out_en && !scl_out);
    assign sda_in = !(sda_out_en && !sda_out) && !sda_pull;

    i2c_subsystem u_dut (
        .clock         (clock),
        .rst           (rst),
        .start         (start),
        .slave_address (slave_address),
        .host_req      (host_req),
        .scl_in        (scl_in),
        .sda_in        (sda_in),
        .host_rdata    (host_rdata),
        .host_rvalid   (host_rvalid),
        .done          (done),
        .scl_out       (scl_out),
        .scl_out_en    (scl_out_en),
        .sda_out       (sda_out),
        .sda_out_en    (sda_out_en)
    );

    always #10 clock = ~clock;

    // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // mask bit 2 covers the address byte, bit 0 the data byte
    function automatic logic ack_for(input int xfer, input int byte_no);
        return patterns[`SYNTH_TABLE_LEN + 1 + xfer][2 - byte_no];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // callers are always at a falling edge, one idle cycle follows
    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        host_req = '0;
        host_req.addr = addr;
        host_req.wdata = data;
        host_req.write = 1'b1;
        @(negedge clock);
        host_req = '0;
        @(negedge clock);
    endtask

    task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
        int   wait_cycles;
        logic seen;
        host_req = '0;
        host_req.addr = addr;
        host_req.read = 1'b1;
        host_reads++;
        @(negedge clock);
        host_req = '0;
        seen = host_rvalid;
        wait_cycles = 1;
        // a parked request answers one cycle later than usual
        while (!seen && wait_cycles < 4) begin
            @(negedge clock);
            wait_cycles++;
            seen = host_rvalid;
        end
        check_value("host read answered", 32'(seen), 32'd1);
        data = host_rdata;
        @(negedge clock);
    endtask

    // slave model, decodes the lines half a cycle after each DUT edge
    always @(negedge clock) begin
        if (rst) begin
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
            in_xfer <= 1'b0;
            sda_pull <= 1'b0;
            bit_cnt <= 0;
            xfer_idx <= 0;
            level_len <= 0;
            min_level <= 32'h7fffffff;
        end else begin
            scl_prev <= scl_in;
            sda_prev <= sda_in;
            level_len <= level_len + 1;
            if (scl_in && scl_prev && sda_prev && !sda_in) begin
                // start condition opens a new transfer
                in_xfer <= 1'b1;
                bit_cnt <= 0;
                level_len <= 1;
            end else if (scl_in && scl_prev && !sda_prev && sda_in && in_xfer) begin
                // stop condition, keep the three bytes without their ack slots
                in_xfer <= 1'b0;
                xfer_idx <= xfer_idx + 1;
                xfers.push_back({shift_in[26:19], shift_in[17:10], shift_in[8:1]});
            end else if (in_xfer && (scl_in != scl_prev)) begin
                if (level_len < min_level) begin
                    min_level <= level_len;
                end
                level_len <= 1;
                if (scl_in) begin
                    // the rise that opens the stop condition carries no bit
                    if (bit_cnt < 27) begin
                        shift_in <= {shift_in[25:0], sda_in};
                    end
                    bit_cnt <= bit_cnt + 1;
                end else if (bit_cnt % 9 == 8) begin
                    // the ninth clock of a byte is the slave's to drive
                    sda_pull <= ack_for(xfer_idx, bit_cnt / 9);
                end else begin
                    sda_pull <= 1'b0;
                end
            end
        end
    end

    always @(negedge clock) begin
        if (rst) begin
            host_responses <= 0;
            done_pulses <= 0;
            stops_at_done <= 0;
        end else begin
            if (host_rvalid) begin
                host_responses <= host_responses + 1;
            end
            if (done) begin
                done_pulses <= done_pulses + 1;
                stops_at_done <= xfer_idx;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rd;
        int          delay;
        logic        nack_expected;
        clock = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        slave_address = SLAVE_ADDR;
        host_req = '0;
        lfsr = 16'd29836;
        $readmemh("sim/i2c_patterns.hex", patterns);
        half_period = patterns[`SYNTH_TABLE_LEN];
        timeout_cycles = `SYNTH_TABLE_LEN * 29 * 2 * int'(half_period) * 2 + 2000;
        // only the last transfer's nack survives until done
        nack_expected = ~&patterns[NUM_PATTERNS-1][2:0];

        repeat (2) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        check_value("scl enable after reset", 32'(scl_out_en), 32'd0);
        check_value("sda enable after reset", 32'(sda_out_en), 32'd0);
        check_value("done after reset", 32'(done), 32'd0);

        host_read(`I2C_REG_PERIOD, rd);
        check_value("period after reset", rd, 32'(`I2C_DEFAULT_HALF_PERIOD));
        host_read(`I2C_REG_STATUS, rd);
        check_value("status after reset", rd, 32'd0);
        host_write(`I2C_REG_PERIOD, 32'(half_period));
        host_read(`I2C_REG_PERIOD, rd);
        check_value("period read back", rd, 32'(half_period));

        start = 1'b1;
        @(negedge clock);
        start = 1'b0;

        // collide with a sequencer request while the first transfer runs
        while (!(in_xfer && bit_cnt >= 4)) begin
            @(negedge clock);
        end
        take_random(5, delay);
        repeat (delay) @(negedge clock);
        while (!(u_dut.seq_req.read || u_dut.seq_req.write)) begin
            @(negedge clock);
        end
        // the first entry is acknowledged throughout, so only busy is set
        host_read(`I2C_REG_STATUS, rd);
        check_value("status read colliding with the sequencer", rd, 32'h1);

        while (done_pulses == 0) begin
            @(negedge clock);
        end
        repeat (20) @(negedge clock);
        check_value("done pulses", 32'(done_pulses), 32'd1);
        check_value("stops seen before done", 32'(stops_at_done), 32'(`SYNTH_TABLE_LEN));
        check_value("scl enable after done", 32'(scl_out_en), 32'd0);
        check_value("sda enable after done", 32'(sda_out_en), 32'd0);
        host_read(`I2C_REG_STATUS, rd);
        check_value("status after done", rd, {30'd0, nack_expected, 1'b0});

        check_value("transfers seen by the slave", 32'(xfers.size()), 32'(`SYNTH_TABLE_LEN));
        for (int i = 0; i < xfers.size() && i < `SYNTH_TABLE_LEN; i++) begin
            check_value($sformatf("address byte of transfer %0d", i),
                        32'(xfers[i][23:16]), 32'({slave_address, 1'b0}));
            check_value($sformatf("register byte of transfer %0d", i),
                        32'(xfers[i][15:8]), 32'(patterns[i][15:8]));
            check_value($sformatf("value byte of transfer %0d", i),
                        32'(xfers[i][7:0]), 32'(patterns[i][7:0]));
        end
        check_value("every scl level lasts a half period", 32'(min_level >= int'(half_period)),
                    32'd1);
        check_value("host responses", 32'(host_responses), 32'(host_reads));

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim/i2c_assertions.sv */
// ==========================================================
// I2C engine assertions
// bus strobe timing and SDA behavior around SCL, bound into
// the write engine
// ==========================================================
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_assertions (
    input logic             clock,
    input logic             rst,
    input i2c_pkg::sb_req_t bus_req,
    input logic [31:0]      bus_rdata,
    input logic             bus_rvalid,
    input logic             scl_in,
    input logic             sda_in,
    input logic [2:0]       state
);

    // engine state encodings right after the start and stop edges
    localparam logic [2:0] ST_START = 3'd1;
    localparam logic [2:0] ST_STOP_END = 3'd6;

    // a falling SDA with SCL high is only allowed as the start condition
    start_only: assert property (@(posedge clock) disable iff (rst)
        (scl_in && $past(scl_in) && $fell(sda_in)) |-> (state == ST_START))
        else $error("SDA fell while SCL was high outside a start condition");

    // and a rising one only as the stop condition
    stop_only: assert property (@(posedge clock) disable iff (rst)
        (scl_in && $past(scl_in) && $rose(sda_in)) |-> (state == ST_STOP_END))
        else $error("SDA rose while SCL was high outside a stop condition");

    // a status read taken while SCL is held low is answered next cycle with busy set
    read_latency: assert property (@(posedge clock) disable iff (rst)
        (bus_req.read && (bus_req.addr == `I2C_REG_STATUS) && !scl_in)
            |=> (bus_rvalid && bus_rdata[0]))
        else $error("status read during a transfer got no busy answer one cycle later");

    strobes_apart: assert property (@(posedge clock) disable iff (rst)
        !(bus_req.write && bus_req.read))
        else $error("write and read strobes were high together");

endmodule

bind i2c_master i2c_assertions u_assertions (
    .clock      (clock),
    .rst        (rst),
    .bus_req    (bus_req),
    .bus_rdata  (bus_rdata),
    .bus_rvalid (bus_rvalid),
    .scl_in     (scl_in),
    .sda_in     (sda_in),
    .state      (state)
);

/* hdl/i2c_subsystem.sv */
// ==========================================================
// I2C configuration subsystem, top level
// the sequencer and the host share the write engine through
// a fixed-priority bus arbiter
// ==========================================================
`timescale 1ns/1ps

module i2c_subsystem (
    input  logic             clock,
    input  logic             rst,
    input  logic             start,
    input  logic [6:0]       slave_address,
    input  i2c_pkg::sb_req_t host_req,
    input  logic             scl_in,
    input  logic             sda_in,
    output logic [31:0]      host_rdata,
    output logic             host_rvalid,
    output logic             done,
    output logic             scl_out,
    output logic             scl_out_en,
    output logic             sda_out,
    output logic             sda_out_en
);

    i2c_pkg::sb_req_t seq_req;
    i2c_pkg::sb_req_t eng_req;
    logic [31:0]      seq_rdata;
    logic             seq_rvalid;
    logic [31:0]      eng_rdata;
    logic             eng_rvalid;

    synth_config u_config (
        .clock         (clock),
        .rst           (rst),
        .start         (start),
        .slave_address (slave_address),
        .rdata         (seq_rdata),
        .rvalid        (seq_rvalid),
        .req           (seq_req),
        .done          (done)
    );

    // the sequencer is master 1 and so takes priority over the host
    sb_arbiter u_arbiter (
        .clock     (clock),
        .rst       (rst),
        .m1_req    (seq_req),
        .m2_req    (host_req),
        .s_rdata   (eng_rdata),
        .s_rvalid  (eng_rvalid),
        .s_req     (eng_req),
        .m1_rdata  (seq_rdata),
        .m1_rvalid (seq_rvalid),
        .m2_rdata  (host_rdata),
        .m2_rvalid (host_rvalid)
    );

    i2c_master u_engine (
        .clock      (clock),
        .rst        (rst),
        .bus_req    (eng_req),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .bus_rdata  (eng_rdata),
        .bus_rvalid (eng_rvalid),
        .scl_out    (scl_out),
        .scl_out_en (scl_out_en),
        .sda_out    (sda_out),
        .sda_out_en (sda_out_en)
    );

endmodule

/* hdl/synth_config.sv */
// ==========================================================
// clock synthesizer configuration sequencer
// after start it writes a fixed register table through the
// I2C engine, polling busy between writes, then pulses done
// ==========================================================
`timescale 1ns/1ps
`include "i2c_consts.svh"

module synth_config (
    input  logic             clock,
    input  logic             rst,
    input  logic             start,
    input  logic [6:0]       slave_address,
    input  logic [31:0]      rdata,
    input  logic             rvalid,
    output i2c_pkg::sb_req_t req,
    output logic             done
);

    localparam int LAST = `SYNTH_TABLE_LEN - 1;
    localparam int IDX_W = $clog2(`SYNTH_TABLE_LEN);

    // register address in the upper byte, value in the lower byte
    localparam logic [15:0] SYNTH_TABLE [0:`SYNTH_TABLE_LEN-1] = '{
        // all outputs off while the PLL is reprogrammed
        16'h03FF,
        // both PLLs take the crystal as reference
        16'h0F00,
        16'h1C0E,
        // multisynth 0 divider
        16'h2C00,
        16'h104F,
        // only CLK0 back on
        16'h03FE
    };

    // the gap state keeps sequencer requests at least two cycles apart
    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITE,
        S_GAP,
        S_POLL,
        S_WAIT
    } seq_state_t;

    seq_state_t        state;
    logic [IDX_W-1:0]  idx;
    logic [15:0]       entry;
    i2c_pkg::i2c_cmd_t cmd;

    assign entry = SYNTH_TABLE[idx];

    always_comb begin
        cmd.dev_addr = slave_address;
        cmd.reg_addr = entry[15:8];
        cmd.data = entry[7:0];
    end

    always_comb begin
        req = '0;
        if (state == S_WRITE) begin
            req.addr = `I2C_REG_CMD;
            req.wdata = {9'd0, cmd};
            req.write = 1'b1;
        end else if (state == S_POLL) begin
            req.addr = `I2C_REG_STATUS;
            req.read = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_IDLE;
            idx <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        idx <= '0;
                        state <= S_WRITE;
                    end
                end
                S_WRITE: state <= S_GAP;
                // busy is already set when the first poll reaches the engine
                S_GAP: state <= S_POLL;
                S_POLL: state <= S_WAIT;
                S_WAIT: begin
                    if (rvalid) begin
                        if (rdata[0]) begin
                            state <= S_POLL;
                        end else if (idx == IDX_W'(LAST)) begin
                            done <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                            state <= S_WRITE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* hdl/i2c_master.sv */
// ==========================================================
// I2C byte-write engine
// register file on the simple bus plus a bit engine that
// sends start, device/register/data bytes with acknowledge
// sampling and stop on open-drain SCL and SDA
// ==========================================================
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_master (
    input  logic             clock,
    input  logic             rst,
    input  i2c_pkg::sb_req_t bus_req,
    input  logic             scl_in,
    input  logic             sda_in,
    output logic [31:0]      bus_rdata,
    output logic             bus_rvalid,
    output logic             scl_out,
    output logic             scl_out_en,
    output logic             sda_out,
    output logic             sda_out_en
);

    // every phase below lasts one SCL half period
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_BIT_LO,
        ST_BIT_HI,
        ST_STOP_LO,
        ST_STOP_HI,
        ST_STOP_END
    } state_t;

    state_t            state;
    i2c_pkg::i2c_cmd_t cmd_in;
    i2c_pkg::i2c_cmd_t cmd_q;
    logic [15:0]       period;
    logic [15:0]       cnt;
    // three bytes with a released slot after each for the acknowledge
    logic [26:0]       frame;
    logic [4:0]        bit_idx;
    logic [3:0]        bit_in_byte;
    logic              nack;
    logic              busy;
    logic              cmd_accept;
    logic              scl_released;
    logic              wait_scl;
    logic              half_done;
    logic              ack_bit;

    assign cmd_in = i2c_pkg::i2c_cmd_t'(bus_req.wdata[22:0]);
    assign busy = (state != ST_IDLE);
    // commands arriving while a transfer runs are dropped
    assign cmd_accept = bus_req.write && (bus_req.addr == `I2C_REG_CMD) && !busy;
    assign ack_bit = (bit_in_byte == 4'd8);

    // in these phases SCL is let go and the count waits for it to read high
    assign scl_released = (state == ST_START) || (state == ST_BIT_HI) ||
                          (state == ST_STOP_HI) || (state == ST_STOP_END);
    assign wait_scl = scl_released && !scl_in;
    assign half_done = !wait_scl && (cnt == period - 16'd1);

    always_ff @(posedge clock) begin
        if (rst) begin
            period <= `I2C_DEFAULT_HALF_PERIOD;
        end else if (bus_req.write && (bus_req.addr == `I2C_REG_PERIOD)) begin
            period <= bus_req.wdata[15:0];
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_accept) begin
            cmd_q <= cmd_in;
        end
    end

    // read data comes back exactly one cycle after the strobe
    always_ff @(posedge clock) begin
        if (rst) begin
            bus_rvalid <= 1'b0;
        end else begin
            bus_rvalid <= bus_req.read;
        end
    end

    always_ff @(posedge clock) begin
        if (bus_req.read) begin
            case (bus_req.addr)
                `I2C_REG_CMD:    bus_rdata <= {9'd0, cmd_q};
                `I2C_REG_PERIOD: bus_rdata <= {16'd0, period};
                `I2C_REG_STATUS: bus_rdata <= {30'd0, nack, busy};
                default:         bus_rdata <= 32'd0;
            endcase
        end
    end

    // half period counter, restarted at every phase change
    always_ff @(posedge clock) begin
        if (rst || (state == ST_IDLE) || half_done) begin
            cnt <= 16'd0;
        end else if (!wait_scl) begin
            cnt <= cnt + 16'd1;
        end
    end

    // the write bit after the device address is always 0
    always_ff @(posedge clock) begin
        if (cmd_accept) begin
            frame <= {cmd_in.dev_addr, 1'b0, 1'b1, cmd_in.reg_addr, 1'b1,
                      cmd_in.data, 1'b1};
        end else if ((state == ST_BIT_HI) && half_done) begin
            frame <= {frame[25:0], 1'b0};
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= ST_IDLE;
            bit_idx <= 5'd0;
            bit_in_byte <= 4'd0;
            nack <= 1'b0;
            scl_out <= 1'b1;
            scl_out_en <= 1'b0;
            sda_out <= 1'b1;
            sda_out_en <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // SDA falls while SCL is still high, which is the start condition
                    if (cmd_accept) begin
                        state <= ST_START;
                        nack <= 1'b0;
                        bit_idx <= 5'd0;
                        bit_in_byte <= 4'd0;
                        sda_out <= 1'b0;
                        sda_out_en <= 1'b1;
                    end
                end
                ST_START: begin
                    if (half_done) begin
                        state <= ST_BIT_LO;
                        scl_out <= 1'b0;
                        scl_out_en <= 1'b1;
                    end
                end
                ST_BIT_LO: begin
                    // updated every cycle here, so SDA moves one clock after SCL falls
                    sda_out <= frame[26];
                    sda_out_en <= !ack_bit;
                    if (half_done) begin
                        state <= ST_BIT_HI;
                        scl_out <= 1'b1;
                        scl_out_en <= 1'b0;
                    end
                end
                ST_BIT_HI: begin
                    if (half_done) begin
                        // a released SDA on the ninth clock means no acknowledge
                        if (ack_bit && sda_in) begin
                            nack <= 1'b1;
                        end
                        scl_out <= 1'b0;
                        scl_out_en <= 1'b1;
                        if (bit_idx == 5'd26) begin
                            state <= ST_STOP_LO;
                        end else begin
                            state <= ST_BIT_LO;
                            bit_idx <= bit_idx + 5'd1;
                            bit_in_byte <= ack_bit ? 4'd0 : bit_in_byte + 4'd1;
                        end
                    end
                end
                ST_STOP_LO: begin
                    sda_out <= 1'b0;
                    sda_out_en <= 1'b1;
                    if (half_done) begin
                        state <= ST_STOP_HI;
                        scl_out <= 1'b1;
                        scl_out_en <= 1'b0;
                    end
                end
                ST_STOP_HI: begin
                    // SDA rises with SCL high, the stop condition
                    if (half_done) begin
                        state <= ST_STOP_END;
                        sda_out <= 1'b1;
                    end
                end
                ST_STOP_END: begin
                    if (half_done) begin
                        state <= ST_IDLE;
                        sda_out_en <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/sb_arbiter.sv */
// ==========================================================
// simple bus arbiter, two masters and one slave
// master 1 has fixed priority, a colliding master 2 request
// is parked for a cycle, read data returns to its issuer
// ==========================================================
`timescale 1ns/1ps

module sb_arbiter (
    input  logic             clock,
    input  logic             rst,
    input  i2c_pkg::sb_req_t m1_req,
    input  i2c_pkg::sb_req_t m2_req,
    input  logic [31:0]      s_rdata,
    input  logic             s_rvalid,
    output i2c_pkg::sb_req_t s_req,
    output logic [31:0]      m1_rdata,
    output logic             m1_rvalid,
    output logic [31:0]      m2_rdata,
    output logic             m2_rvalid
);

    i2c_pkg::sb_req_t held_req;
    logic             held_valid;
    logic             m1_act;
    logic             m2_act;
    logic             grant_m2;
    // set when the read in flight belongs to master 2
    logic             owner;

    assign m1_act = m1_req.write | m1_req.read;
    assign m2_act = m2_req.write | m2_req.read;

    // master 1 always wins, a parked request goes before a new one
    always_comb begin
        s_req = '0;
        grant_m2 = 1'b0;
        if (m1_act) begin
            s_req = m1_req;
        end else if (held_valid) begin
            s_req = held_req;
            grant_m2 = 1'b1;
        end else if (m2_act) begin
            s_req = m2_req;
            grant_m2 = 1'b1;
        end
    end

    // the parked copy of a master 2 request that lost the slot
    always_ff @(posedge clock) begin
        if (m1_act && m2_act) begin
            held_req <= m2_req;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            held_valid <= 1'b0;
            owner <= 1'b0;
        end else begin
            // the parked request leaves as soon as master 1 is quiet
            if (m1_act && m2_act) begin
                held_valid <= 1'b1;
            end else if (!m1_act) begin
                held_valid <= 1'b0;
            end
            // the slave answers one cycle later, so owner lines up with rvalid
            if (s_req.read) begin
                owner <= grant_m2;
            end
        end
    end

    // only the issuing master sees a response
    assign m1_rvalid = s_rvalid & ~owner;
    assign m2_rvalid = s_rvalid & owner;
    assign m1_rdata = owner ? 32'd0 : s_rdata;
    assign m2_rdata = owner ? s_rdata : 32'd0;

endmodule

/* hdl/i2c_pkg.sv */
// ==========================================================
// I2C subsystem types
// bus request and I2C command layouts shared by the
// sequencer, the arbiter and the write engine
// ==========================================================
package i2c_pkg;

    // one request on the simple bus, strobes are single cycle
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic        write;
        logic        read;
    } sb_req_t;

    // contents of the command register
    // it sits in the low 23 bits of wdata, dev_addr on top
    typedef struct packed {
        logic [6:0] dev_addr;
        logic [7:0] reg_addr;
        logic [7:0] data;
    } i2c_cmd_t;

endpackage

/* hdl/i2c_consts.svh */
// ==========================================================
// I2C subsystem constants
// register offsets of the I2C write engine, the reset value
// of the SCL half period and the synthesizer table length
// ==========================================================
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// a write to the command register starts one transaction
`define I2C_REG_CMD 8'h00
// SCL half period in clocks, read/write, 16 bits wide
`define I2C_REG_PERIOD 8'h10
// read-only status, bit 0 is busy and bit 1 the sticky nack
`define I2C_REG_STATUS 8'h14

// half period after reset
`define I2C_DEFAULT_HALF_PERIOD 16'd8

// number of register/value pairs the sequencer writes
`define SYNTH_TABLE_LEN 6

`endif
